//--- hdl/axi_pkg.sv
// AXI3 field encodings for the bridge; single id, incrementing bursts and full words only
package axi_pkg;

    // burst length field holds beats minus one
    localparam logic [3:0] axi_len_line = 4'd3;

    localparam logic [3:0] axi_len_single = 4'd0;

    // four bytes per beat
    localparam logic [2:0] axi_size_word = 3'd2;

    localparam logic [1:0] axi_burst_incr = 2'd1;

    // only okay is produced by a well-behaved slave here
    localparam logic [1:0] axi_resp_okay = 2'd0;

endpackage

//--- hdl/mem_pkg.sv
// memory side types and constants; fixed MIPS segments, one 4-word line, word accesses only
package mem_pkg;

    typedef logic [31:0] word_t;

    // one virtual or physical address, seen either by segment or by line position
    typedef union packed {
        struct packed {
            logic [2:0]  seg;
            logic [28:0] offset;
        } seg_view;
        struct packed {
            logic [27:0] tag;
            logic [1:0]  index;
            logic [1:0]  offset;
        } line_view;
    } vaddr_u;

    // top three address bits
    localparam logic [2:0] seg_kseg0 = 3'b100;

    localparam logic [2:0] seg_kseg1 = 3'b101;

    // words per line
    localparam int line_words = 4;

    // cpu size code of a full 32-bit access
    localparam logic [1:0] size_word = 2'd2;

endpackage

//--- hdl/bus_ifs.sv
// internal CPU-side and line buses; one request in flight, no byte enables
`timescale 1ns/1ns

// sram-like request bus, req held until addr_ok, data_ok pulses once
interface sramx_if import mem_pkg::*; ();
    logic  req;
    logic  wr;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  addr_ok;
    logic  data_ok;

    modport master (
        output req, wr, addr, wdata,
        input  rdata, addr_ok, data_ok
    );

    modport slave (
        input  req, wr, addr, wdata,
        output rdata, addr_ok, data_ok
    );
endinterface

// whole-line transfer bus, four beats per valid
interface cbus_if import mem_pkg::*; ();
    logic  valid;
    logic  is_write;
    word_t addr;
    word_t wdata;
    logic  ready;
    logic  last;
    word_t rdata;

    modport master (
        output valid, is_write, addr, wdata,
        input  ready, last, rdata
    );

    modport slave (
        input  valid, is_write, addr, wdata,
        output ready, last, rdata
    );
endinterface

//--- hdl/addr_dispatch.sv
// fixed segment translation without TLB or exceptions; one request outstanding at a time
`timescale 1ns/1ns

module addr_dispatch import mem_pkg::*; (
    input logic    aclk,
    input logic    reset,
    sramx_if.slave  cpu,
    sramx_if.master cached_bus,
    sramx_if.master uncached_bus
);
    vaddr_u vaddr;
    vaddr_u paddr;
    logic   to_uncached;
    logic   busy;
    logic   busy_uncached;

    assign vaddr       = cpu.addr;
    assign to_uncached = vaddr.seg_view.seg == seg_kseg1;

    always_comb begin
        paddr = vaddr;
        if (vaddr.seg_view.seg == seg_kseg0) begin
            paddr.seg_view.seg[2] = 1'b0;
        end else if (to_uncached) begin
            paddr.seg_view.seg = 3'b000;
        end
    end

    assign cached_bus.req     = cpu.req && !busy && !to_uncached;
    assign cached_bus.wr      = cpu.wr;
    assign cached_bus.addr    = paddr;
    assign cached_bus.wdata   = cpu.wdata;
    assign uncached_bus.req   = cpu.req && !busy && to_uncached;
    assign uncached_bus.wr    = cpu.wr;
    assign uncached_bus.addr  = paddr;
    assign uncached_bus.wdata = cpu.wdata;

    // acceptance comes straight from the selected side
    assign cpu.addr_ok = !busy && (to_uncached ? uncached_bus.addr_ok : cached_bus.addr_ok);
    assign cpu.data_ok = busy_uncached ? uncached_bus.data_ok : cached_bus.data_ok;
    assign cpu.rdata   = busy_uncached ? uncached_bus.rdata : cached_bus.rdata;

    always_ff @(posedge aclk) begin
        if (reset) begin
            busy          <= 1'b0;
            busy_uncached <= 1'b0;
        end else if (cpu.req && cpu.addr_ok) begin
            busy          <= 1'b1;
            busy_uncached <= to_uncached;
        end else if (cpu.data_ok) begin
            busy <= 1'b0;
        end
    end

endmodule

//--- hdl/line_buffer.sv
// single 4-word write-back line; a miss evicts a dirty line before the refill, req must stay held
`timescale 1ns/1ns

module line_buffer import mem_pkg::*; (
    input logic    aclk,
    input logic    reset,
    sramx_if.slave  cpu,
    cbus_if.master  line
);
    vaddr_u      req_addr;
    logic [27:0] tag_q;
    word_t       data_q [line_words];
    logic        valid_q;
    logic        dirty_q;
    logic        evicting;
    logic        refilling;
    logic [1:0]  beat;
    logic        hit;
    logic        data_ok_q;
    word_t       rdata_q;

    assign req_addr = cpu.addr;
    assign hit      = valid_q && (tag_q == req_addr.line_view.tag);

    // only served from the line, never during a transfer
    assign cpu.addr_ok = cpu.req && hit && !evicting && !refilling;
    assign cpu.data_ok = data_ok_q;
    assign cpu.rdata   = rdata_q;

    assign line.valid    = evicting || refilling;
    assign line.is_write = evicting;
    assign line.addr     = {(evicting ? tag_q : req_addr.line_view.tag), 4'b0000};
    assign line.wdata    = data_q[beat];

    // line storage and read data
    always_ff @(posedge aclk) begin
        if (refilling && line.ready) begin
            data_q[beat] <= line.rdata;
        end else if (cpu.addr_ok && cpu.wr) begin
            data_q[req_addr.line_view.index] <= cpu.wdata;
        end
        if (cpu.addr_ok) begin
            rdata_q <= data_q[req_addr.line_view.index];
        end
        if (refilling && line.ready && line.last) begin
            tag_q <= req_addr.line_view.tag;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            dirty_q   <= 1'b0;
            evicting  <= 1'b0;
            refilling <= 1'b0;
            beat      <= 2'd0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= cpu.addr_ok;
            if (line.ready) begin
                beat <= beat + 2'd1;
            end
            if (cpu.addr_ok && cpu.wr) begin
                dirty_q <= 1'b1;
            end
            // miss while idle
            if (!line.valid && cpu.req && !hit) begin
                if (valid_q && dirty_q) begin
                    evicting <= 1'b1;
                end else begin
                    refilling <= 1'b1;
                    valid_q   <= 1'b0;
                end
            end
            if (evicting && line.ready && line.last) begin
                evicting  <= 1'b0;
                refilling <= 1'b1;
                valid_q   <= 1'b0;
                dirty_q   <= 1'b0;
            end
            if (refilling && line.ready && line.last) begin
                refilling <= 1'b0;
                valid_q   <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/axi_master.sv
// one AXI3 master for line bursts and uncached beats; line wins, rresp and bresp are not checked
`timescale 1ns/1ns

module axi_master import mem_pkg::*, axi_pkg::*; (
    input  logic        aclk,
    input  logic        reset,
    cbus_if.slave       line,
    sramx_if.slave      single,
    output logic [31:0] araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [3:0]  awlen,
    output logic [2:0]  awsize,
    output logic [1:0]  awburst,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    output logic        bready
);
    logic       idle;
    logic       owner_line;
    logic       data_ok_q;
    word_t      addr_q;
    word_t      wdata_q;
    word_t      rdata_q;
    logic [3:0] beat;

    // each channel flag is one FSM state, none set means idle
    assign idle = !(arvalid || rready || awvalid || wvalid || bready);

    assign single.addr_ok = idle && single.req && !line.valid;
    assign single.data_ok = data_ok_q;
    assign single.rdata   = rdata_q;

    assign araddr  = addr_q;
    assign awaddr  = addr_q;
    assign arlen   = owner_line ? axi_len_line : axi_len_single;
    assign awlen   = owner_line ? axi_len_line : axi_len_single;
    assign arsize  = axi_size_word;
    assign awsize  = axi_size_word;
    assign arburst = axi_burst_incr;
    assign awburst = axi_burst_incr;
    assign wdata   = owner_line ? line.wdata : wdata_q;
    assign wstrb   = 4'hf;
    assign wlast   = beat == awlen;

    // final write beat of a line is acknowledged on b, not on w
    assign line.rdata = rdata;
    assign line.ready = owner_line && ((rready && rvalid) || (wvalid && wready && !wlast)
                        || (bready && bvalid));
    assign line.last  = owner_line && ((rready && rvalid && rlast) || (bready && bvalid));

    always_ff @(posedge aclk) begin
        if (idle) begin
            addr_q  <= line.valid ? line.addr : single.addr;
            wdata_q <= single.wdata;
        end
        if (rready && rvalid && !owner_line) begin
            rdata_q <= rdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            bready     <= 1'b0;
            owner_line <= 1'b0;
            beat       <= 4'd0;
            data_ok_q  <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            if (line.valid || single.addr_ok) begin
                if (idle) begin
                    owner_line <= line.valid;
                    if (line.valid ? line.is_write : single.wr) begin
                        awvalid <= 1'b1;
                    end else begin
                        arvalid <= 1'b1;
                    end
                end
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (rready && rvalid && rlast) begin
                rready    <= 1'b0;
                data_ok_q <= !owner_line;
            end
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b1;
            end
            if (wvalid && wready) begin
                beat <= beat + 4'd1;
                if (wlast) begin
                    wvalid <= 1'b0;
                    bready <= 1'b1;
                    beat   <= 4'd0;
                end
            end
            if (bready && bvalid) begin
                bready    <= 1'b0;
                data_ok_q <= !owner_line;
            end
        end
    end

endmodule

//--- hdl/mem_bridge_top.sv
// CPU data port to AXI3 bridge; data_size is ignored since every access is a full word
`timescale 1ns/1ns

module mem_bridge_top import mem_pkg::*; (
    input  logic        aclk,
    input  logic        reset,
    input  logic        data_req,
    input  logic        data_wr,
    input  logic [1:0]  data_size,
    input  word_t       data_addr,
    input  word_t       data_wdata,
    output word_t       data_rdata,
    output logic        data_addr_ok,
    output logic        data_data_ok,
    output logic [31:0] araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [3:0]  awlen,
    output logic [2:0]  awsize,
    output logic [1:0]  awburst,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    output logic        bready
);
    sramx_if cpu ();
    sramx_if cached_bus ();
    sramx_if uncached_bus ();
    cbus_if  line ();

    assign cpu.req      = data_req;
    assign cpu.wr       = data_wr;
    assign cpu.addr     = data_addr;
    assign cpu.wdata    = data_wdata;
    assign data_rdata   = cpu.rdata;
    assign data_addr_ok = cpu.addr_ok;
    assign data_data_ok = cpu.data_ok;

    addr_dispatch u_dispatch (
        .aclk,
        .reset,
        .cpu          (cpu.slave),
        .cached_bus   (cached_bus.master),
        .uncached_bus (uncached_bus.master)
    );

    line_buffer u_line_buffer (
        .aclk,
        .reset,
        .cpu  (cached_bus.slave),
        .line (line.master)
    );

    axi_master u_axi_master (
        .aclk,
        .reset,
        .line   (line.slave),
        .single (uncached_bus.slave),
        .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
        .rdata, .rresp, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bresp, .bvalid, .bready
    );

endmodule

//--- verification/mem_bridge_checker.sv
// watches the CPU and AXI ports of the bridge; keeps its own one-line model, reads the tests from tb
`timescale 1ns/1ns

module mem_bridge_checker import mem_pkg::*; (
    input  logic         aclk,
    input  logic         reset,
    input  logic         data_req,
    input  logic         data_wr,
    input  word_t        data_addr,
    input  word_t        data_rdata,
    input  logic         data_addr_ok,
    input  logic         data_data_ok,
    input  logic [31:0]  araddr,
    input  logic [3:0]   arlen,
    input  logic [2:0]   arsize,
    input  logic [1:0]   arburst,
    input  logic         arvalid,
    input  logic         arready,
    input  logic [31:0]  awaddr,
    input  logic [3:0]   awlen,
    input  logic [2:0]   awsize,
    input  logic [1:0]   awburst,
    input  logic         awvalid,
    input  logic         awready,
    input  logic [3:0]   wstrb,
    input  logic         wvalid,
    input  logic         wready,
    input  logic         wlast,
    input  logic [127:0] test_name,
    input  word_t        test_exp,
    input  logic         test_rd,
    output int           mismatches,
    output int           failures
);
    logic        pending;
    logic        pend_unc;
    logic        cached_ack;
    word_t       pend_phys;
    int          axi_seen;
    int          axi_expected;
    int          w_beats;
    logic [3:0]  aw_len_q;
    logic        line_valid;
    logic        line_dirty;
    logic [27:0] line_tag;

    // fixed segment mapping
    function automatic word_t translate(input word_t a);
        if (a[31:29] == seg_kseg0) begin
            return a & 32'h7fffffff;
        end else if (a[31:29] == seg_kseg1) begin
            return a & 32'h1fffffff;
        end
        return a;
    endfunction

    always @(negedge aclk) begin : check_edge
        word_t       phys;
        word_t       exp_addr;
        logic [3:0]  exp_len;
        logic        unc;
        logic [27:0] ptag;
        if (reset) begin
            pending    = 1'b0;
            pend_unc   = 1'b0;
            cached_ack = 1'b0;
            pend_phys  = '0;
            axi_seen   = 0;
            axi_expected = 0;
            w_beats    = 0;
            aw_len_q   = '0;
            line_valid = 1'b0;
            line_dirty = 1'b0;
            line_tag   = '0;
            mismatches = 0;
            failures   = 0;
        end else begin
            phys = pending ? pend_phys : translate(data_addr);
            unc  = pending ? pend_unc : (data_addr[31:29] == seg_kseg1);
            if (cached_ack && !data_data_ok) begin
                failures++;
                $display("%s: cached data_ok did not follow addr_ok by one cycle", test_name);
            end
            cached_ack = 1'b0;
            if (arvalid && arready) begin
                axi_seen++;
                // one beat uncached, four beats for a line
                exp_len  = unc ? 4'd0 : 4'd3;
                exp_addr = unc ? phys : {phys[31:4], 4'h0};
                if (arlen != exp_len) begin
                    failures++;
                    $display("%s: read burst had length field %0d instead of %0d",
                             test_name, arlen, exp_len);
                end
                // four-byte beats, incrementing
                if (arsize != 3'd2 || arburst != 2'd1) begin
                    failures++;
                    $display("%s: read burst had size %0d and type %0d, not word increments",
                             test_name, arsize, arburst);
                end
                if (araddr != exp_addr) begin
                    mismatches++;
                    $display("mismatch %s araddr expected %08h actual %08h",
                             test_name, exp_addr, araddr);
                end
            end
            if (awvalid && awready) begin
                axi_seen++;
                // an eviction writes the old line back
                exp_len  = unc ? 4'd0 : 4'd3;
                exp_addr = unc ? phys : {line_tag, 4'h0};
                aw_len_q = awlen;
                w_beats  = 0;
                if (awlen != exp_len) begin
                    failures++;
                    $display("%s: write burst had length field %0d instead of %0d",
                             test_name, awlen, exp_len);
                end
                if (awsize != 3'd2 || awburst != 2'd1) begin
                    failures++;
                    $display("%s: write burst had size %0d and type %0d, not word increments",
                             test_name, awsize, awburst);
                end
                if (awaddr != exp_addr) begin
                    mismatches++;
                    $display("mismatch %s awaddr expected %08h actual %08h",
                             test_name, exp_addr, awaddr);
                end
            end
            if (wvalid && wready) begin
                w_beats++;
                if (wstrb != 4'hf) begin
                    failures++;
                    $display("%s: write beat did not enable all four bytes", test_name);
                end
                if (wlast && w_beats != int'(aw_len_q) + 1) begin
                    failures++;
                    $display("%s: write burst ended after %0d beats", test_name, w_beats);
                end
            end
            if (data_req && data_addr_ok) begin
                ptag = phys[31:4];
                if (unc) begin
                    axi_expected = 1;
                end else if (line_valid && line_tag == ptag) begin
                    axi_expected = 0;
                end else begin
                    axi_expected = (line_valid && line_dirty) ? 2 : 1;
                end
                if (!unc) begin
                    if (axi_expected != 0) begin
                        line_dirty = 1'b0;
                    end
                    line_valid = 1'b1;
                    line_tag   = ptag;
                    line_dirty = line_dirty | data_wr;
                    cached_ack = 1'b1;
                end
                pending   = 1'b1;
                pend_phys = phys;
                pend_unc  = unc;
            end
            if (data_data_ok) begin
                if (!pending) begin
                    failures++;
                    $display("data_ok arrived while no request was outstanding");
                end else begin
                    if (test_rd && data_rdata != test_exp) begin
                        mismatches++;
                        $display("mismatch %s expected %08h actual %08h",
                                 test_name, test_exp, data_rdata);
                    end
                    if (axi_seen != axi_expected) begin
                        failures++;
                        $display("%s: saw %0d AXI transactions where %0d were due",
                                 test_name, axi_seen, axi_expected);
                    end
                end
                pending  = 1'b0;
                axi_seen = 0;
            end
        end
    end

endmodule

//--- verification/mem_bridge_tb.sv
// drives the bridge from the tests file, models an AXI slave with random delays; run from root
`timescale 1ns/1ns

module mem_bridge_tb import mem_pkg::*, axi_pkg::*; ();
    logic         aclk;
    logic         reset;
    logic         data_req;
    logic         data_wr;
    logic [1:0]   data_size;
    word_t        data_addr;
    word_t        data_wdata;
    word_t        data_rdata;
    logic         data_addr_ok;
    logic         data_data_ok;
    logic [31:0]  araddr;
    logic [3:0]   arlen;
    logic [2:0]   arsize;
    logic [1:0]   arburst;
    logic         arvalid;
    logic         arready;
    logic [31:0]  rdata;
    logic [1:0]   rresp;
    logic         rlast;
    logic         rvalid;
    logic         rready;
    logic [31:0]  awaddr;
    logic [3:0]   awlen;
    logic [2:0]   awsize;
    logic [1:0]   awburst;
    logic         awvalid;
    logic         awready;
    logic [31:0]  wdata;
    logic [3:0]   wstrb;
    logic         wlast;
    logic         wvalid;
    logic         wready;
    logic [1:0]   bresp;
    logic         bvalid;
    logic         bready;

    logic [127:0] name_q [$];
    logic         op_wr_q [$];
    word_t        addr_q [$];
    word_t        wdata_q [$];
    word_t        exp_q [$];
    logic [127:0] cur_name;
    word_t        cur_exp;
    logic         cur_rd;
    word_t        slave_mem [word_t];
    logic [31:0]  lfsr_state;
    int           cycles;
    int           cycle_limit;
    int           mismatches;
    int           failures;

    mem_bridge_top u_dut (
        .aclk, .reset,
        .data_req, .data_wr, .data_size, .data_addr, .data_wdata,
        .data_rdata, .data_addr_ok, .data_data_ok,
        .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
        .rdata, .rresp, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bresp, .bvalid, .bready
    );

    mem_bridge_checker u_check (
        .aclk, .reset,
        .data_req, .data_wr, .data_addr, .data_rdata, .data_addr_ok, .data_data_ok,
        .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
        .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
        .wstrb, .wvalid, .wready, .wlast,
        .test_name (cur_name),
        .test_exp  (cur_exp),
        .test_rd   (cur_rd),
        .mismatches,
        .failures
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // 0 to 3 cycles, one LFSR step per bit
    task automatic random_delay(output int d);
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            d = d * 2 + int'(lfsr_state[0]);
        end
    endtask

    function automatic word_t mem_read(input word_t a);
        if (slave_mem.exists(a)) begin
            return slave_mem[a];
        end
        return a ^ 32'h5a5a5a5a;
    endfunction

    task automatic next_cycle;
        @(posedge aclk);
        #1;
    endtask

    task automatic serve_read;
        word_t      base;
        logic [3:0] len;
        int         d;
        logic       taken;
        random_delay(d);
        repeat (d) next_cycle;
        base    = araddr;
        len     = arlen;
        arready = 1'b1;
        next_cycle;
        arready = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            random_delay(d);
            repeat (d) next_cycle;
            rvalid = 1'b1;
            rdata  = mem_read(base + 32'(i * 4));
            rlast  = (i == int'(len));
            taken  = 1'b0;
            while (!taken) begin
                taken = rready;
                next_cycle;
            end
            rvalid = 1'b0;
            rlast  = 1'b0;
        end
    endtask

    task automatic serve_write;
        word_t      base;
        logic [3:0] len;
        int         d;
        logic       taken;
        random_delay(d);
        repeat (d) next_cycle;
        base    = awaddr;
        len     = awlen;
        awready = 1'b1;
        next_cycle;
        awready = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            random_delay(d);
            repeat (d) next_cycle;
            wready = 1'b1;
            taken  = 1'b0;
            while (!taken) begin
                taken = wvalid;
                if (wvalid) begin
                    slave_mem[base + 32'(i * 4)] = wdata;
                end
                next_cycle;
            end
            wready = 1'b0;
        end
        random_delay(d);
        repeat (d) next_cycle;
        bvalid = 1'b1;
        taken  = 1'b0;
        while (!taken) begin
            taken = bready;
            next_cycle;
        end
        bvalid = 1'b0;
    endtask

    // slave serves one transaction at a time
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        rresp   = axi_resp_okay;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = axi_resp_okay;
        forever begin
            next_cycle;
            if (arvalid === 1'b1) begin
                serve_read;
            end else if (awvalid === 1'b1) begin
                serve_write;
            end
        end
    end

    task automatic load_tests;
        int           fd;
        int           n;
        string        line_str;
        string        op;
        logic [127:0] nm;
        word_t        a;
        word_t        w;
        word_t        e;
        fd = $fopen("verification/mem_bridge_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line_str, fd);
            if (n > 0 && line_str.substr(0, 0) != "#") begin
                if ($sscanf(line_str, "%s %s %h %h %h", nm, op, a, w, e) == 5) begin
                    name_q.push_back(nm);
                    op_wr_q.push_back(op == "wr");
                    addr_q.push_back(a);
                    wdata_q.push_back(w);
                    exp_q.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    // req held until addr_ok, then wait for data_ok
    task automatic run_test(input int idx);
        logic seen;
        next_cycle;
        cur_name   = name_q[idx];
        cur_exp    = exp_q[idx];
        cur_rd     = !op_wr_q[idx];
        data_req   = 1'b1;
        data_wr    = op_wr_q[idx];
        data_addr  = addr_q[idx];
        data_wdata = wdata_q[idx];
        seen = 1'b0;
        while (!seen) begin
            @(negedge aclk);
            seen = data_addr_ok;
            next_cycle;
        end
        data_req = 1'b0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge aclk);
            seen = data_data_ok;
        end
    endtask

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        lfsr_state  = 32'hef5c3019;
        cycles      = 0;
        cycle_limit = 0;
        reset       = 1'b1;
        data_req    = 1'b0;
        data_wr     = 1'b0;
        data_size   = size_word;
        data_addr   = '0;
        data_wdata  = '0;
        cur_name    = '0;
        cur_exp     = '0;
        cur_rd      = 1'b0;
        load_tests;
        cycle_limit = name_q.size() * 200 + 8;
        repeat (8) @(posedge aclk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < name_q.size(); i++) begin
            run_test(i);
        end
        repeat (4) next_cycle;
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (name_q.size() > 0 && mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- mem_bridge.f
hdl/axi_pkg.sv
hdl/mem_pkg.sv
hdl/bus_ifs.sv
hdl/addr_dispatch.sv
hdl/line_buffer.sv
hdl/axi_master.sv
hdl/mem_bridge_top.sv
verification/mem_bridge_checker.sv
verification/mem_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds with Verilator from the file list and runs from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mem_bridge.f --top-module mem_bridge_tb \
    -o mem_bridge_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/mem_bridge_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -q "Test failed" sim.log && exit 1 || exit 0

//--- verification/mem_bridge_tests.txt
# name op(rd/wr) cpu_addr(hex) write_data(hex) expected_read_data(hex)
# unwritten memory reads as physical address xor 5a5a5a5a
rd_kseg0_miss rd 80001004 00000000 5a5a4a5e
rd_kseg0_hit rd 8000100c 00000000 5a5a4a56
rd_kseg1 rd a0002000 00000000 5a5a7a5a
wr_kseg1 wr a0002004 11223344 00000000
rd_kseg1_back rd a0002004 00000000 11223344
rd_line_kept rd 80001000 00000000 5a5a4a5a
wr_line_word wr 80001008 cafef00d 00000000
rd_line_word rd 80001008 00000000 cafef00d
rd_evict_miss rd 80003010 00000000 5a5a6a4a
rd_evicted_w0 rd a0001000 00000000 5a5a4a5a
rd_evicted_w1 rd a0001004 00000000 5a5a4a5e
rd_evicted_w2 rd a0001008 00000000 cafef00d
rd_evicted_w3 rd a000100c 00000000 5a5a4a56
rd_kuseg_miss rd 00005000 00000000 5a5a0a5a
wr_kuseg_hit wr 0000500c 0badf00d 00000000
rd_kseg0_high rd 9000500c 00000000 4a5a0a56
rd_kuseg_evicted rd a000500c 00000000 0badf00d
rd_kuseg_alias rd 1000500c 00000000 4a5a0a56
rd_top_line rd 8000f3fc 00000000 5a5aa9a6
wr_unc_alias wr a000f3fc 00000001 00000000
rd_stale_line rd 8000f3fc 00000000 5a5aa9a6
rd_unc_alias rd a000f3fc 00000000 00000001
wr_top_word wr 8000f3f0 12345678 00000000
rd_zero_miss rd 80000000 00000000 5a5a5a5a
rd_top_w0 rd a000f3f0 00000000 12345678
rd_top_w3 rd a000f3fc 00000000 5a5aa9a6
rd_top_w1 rd a000f3f4 00000000 5a5aa9ae
rd_zero_hit rd 80000008 00000000 5a5a5a52
